// ==== files.f ====
+incdir+tb
common/dot11_tx_pkg.sv
hdl/data_scrambler.sv
hdl/fcs_crc32.sv
hdl/conv_encoder.sv
framer/tx_framer.sv
hdl/dot11_tx_top.sv
tb/tb_dot11_tx.sv

// ==== tb/tx_stim.txt ====
// rate  length  seed  stall%  pairs   (hex columns, one packet per line)
// length is in bytes and counts the FCS, a zero length ends the list
B 064 5D 00 360
B 064 5D 28 360
F 03C 7F 00 210
A 005 01 19 078
E 0C8 2A 00 690
9 096 33 32 4F8
D 040 11 00 258
8 12C 6E 1E 9D8
C 021 45 00 1C8
3 009 1B 0A 078
B 005 40 3C 060
0 000 00 00 000

// ==== tb/tx_ref_model.svh ====
/*
  Behavioral reference for the transmit bit pipeline: rate table, scrambler,
  CRC-32, convolutional encoder and pair count. Included by the testbench.
*/
`ifndef TX_REF_MODEL_SVH
`define TX_REF_MODEL_SVH

// Data bits per OFDM symbol, unknown codes send at 6 Mbps
function automatic int rate_dbps(input logic [3:0] code);
    case (code)
        4'hB: return 24;
        4'hF: return 36;
        4'hA: return 48;
        4'hE: return 72;
        4'h9: return 96;
        4'hD: return 144;
        4'h8: return 192;
        4'hC: return 216;
        default: return 24;
    endcase
endfunction

// SIGNAL pairs plus whole symbols of SERVICE, PSDU, tail and pad
function automatic int pair_count(input int n_dbps, input int len);
    int n_sym;
    n_sym = (22 + 8 * len + n_dbps - 1) / n_dbps;
    return 24 + n_sym * n_dbps;
endfunction

// Generator x^7 + x^4 + 1
function automatic logic scram_mask(input logic [6:0] s);
    return s[6] ^ s[3];
endfunction

function automatic logic [6:0] scram_next(input logic [6:0] s);
    return {s[5:0], s[6] ^ s[3]};
endfunction

// One bit of the reflected 802.3 CRC
function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    return (c >> 1) ^ ((c[0] ^ b) ? 32'hEDB8_8320 : 32'h0);
endfunction

// win[5] is one bit back, win[0] is six bits back
function automatic logic [1:0] enc_pair(input logic [5:0] win, input logic b);
    logic [6:0] taps;
    taps = {b, win};
    return {^(taps & 7'o171), ^(taps & 7'o133)};
endfunction

function automatic logic [5:0] enc_next(input logic [5:0] win, input logic b);
    return {b, win[5:1]};
endfunction

`endif

// ==== tb/tb_dot11_tx.sv ====
/*
  Testbench for the 802.11a transmit bit pipeline. Packets are listed in
  tb/tx_stim.txt and every coded pair is checked against the reference model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dot11_tx;
    import dot11_tx_pkg::*;

    `include "tx_ref_model.svh"

    localparam int STIM_COLS = 5;
    localparam int STIM_SIZE = 64;

    logic                  clk;
    logic                  reset_int;
    logic                  i_tx_start;
    logic [SCRAM_W-1:0]    i_seed;
    logic [MEM_ADDR_W-1:0] o_mem_addr;
    logic [MEM_WORD_W-1:0] i_mem_data;
    coded_pair_t           o_coded;
    logic                  o_coded_valid;
    logic                  i_coded_ready;
    logic                  o_tx_done;

    logic [MEM_WORD_W-1:0] mem [0:(1 << MEM_ADDR_W) - 1];
    logic [15:0]           stim [0:STIM_SIZE - 1];
    logic [1:0]            exp_q [$];
    int                    errors;
    int                    checks;
    bit                    timed_out;

    dot11_tx_top UUT (
        .clk           (clk),
        .reset_int     (reset_int),
        .i_tx_start    (i_tx_start),
        .i_seed        (i_seed),
        .o_mem_addr    (o_mem_addr),
        .i_mem_data    (i_mem_data),
        .o_coded       (o_coded),
        .o_coded_valid (o_coded_valid),
        .i_coded_ready (i_coded_ready),
        .o_tx_done     (o_tx_done)
    );

    // Asynchronous word memory
    assign i_mem_data = mem[o_mem_addr];

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Packet setup and prediction
    ////////////////////////////////////////////////////////////////////
    task automatic fill_memory(input logic [3:0] rate, input int len);
        logic [23:0] sig;
        for (int a = 0; a < (1 << MEM_ADDR_W); a++)
            mem[a] = {4'hC, {6{a[9:0]}}};
        sig       = '0;
        sig[3:0]  = rate;
        sig[16:5] = len[11:0];
        sig[17]   = ^sig[16:0];
        mem[0]    = {mem[0][63:24], sig};
        for (int k = 0; k < 8 * len - 32; k++)
            mem[PSDU_BASE_ADDR + k / 64][k % 64] = $urandom % 2;
    endtask

    task automatic build_expected(input logic [3:0] rate, input int len,
                                  input logic [6:0] seed);
        logic [5:0]  win;
        logic [6:0]  scr;
        logic [31:0] crc;
        logic        raw;
        logic        scrambled;
        int          n_pay;
        int          k;
        exp_q.delete();
        win = '0;
        for (int i = 0; i < 24; i++) begin
            exp_q.push_back(enc_pair(win, mem[0][i]));
            win = enc_next(win, mem[0][i]);
        end
        // DATA restarts the encoder, scrambler runs from the seed
        win   = '0;
        scr   = seed;
        crc   = '1;
        n_pay = 8 * len - 32;
        for (int d = 0; d < pair_count(rate_dbps(rate), len) - 24; d++) begin
            k         = d - 16;
            raw       = 1'b0;
            scrambled = 1'b1;
            if (k >= 0 && k < n_pay) begin
                raw = mem[PSDU_BASE_ADDR + k / 64][k % 64];
                crc = crc_step(crc, raw);
            end else if (k >= n_pay && k < n_pay + 32) begin
                raw = ~crc[k - n_pay];
            end else if (k >= n_pay + 32 && k < n_pay + 38) begin
                scrambled = 1'b0;
            end
            if (scrambled) begin
                raw = raw ^ scram_mask(scr);
                scr = scram_next(scr);
            end
            exp_q.push_back(enc_pair(win, raw));
            win = enc_next(win, raw);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // One packet from start to done
    ////////////////////////////////////////////////////////////////////
    task automatic run_packet(input int idx);
        int         base;
        int         stall;
        int         n_exp;
        int         got;
        bit         finished;
        bit         stalled;
        logic [1:0] held;
        base  = idx * STIM_COLS;
        stall = stim[base + 3];
        n_exp = stim[base + 4];
        fill_memory(stim[base][3:0], stim[base + 1]);
        build_expected(stim[base][3:0], stim[base + 1], stim[base + 2][6:0]);
        checks++;
        if (n_exp != exp_q.size()) begin
            errors++;
            $display("error at %0t: packet %0d stim count %0d, model count %0d",
                     $time, idx, n_exp, exp_q.size());
        end
        got      = 0;
        finished = 1'b0;
        stalled  = 1'b0;
        held     = '0;
        @(posedge clk);
        #1;
        i_seed     = stim[base + 2][6:0];
        i_tx_start = 1'b1;
        for (int cyc = 0; cyc < 8 * n_exp + 100 && !finished; cyc++) begin
            @(negedge clk);
            checks++;
            if (stalled && o_coded.ab !== held) begin
                errors++;
                $display("error at %0t: packet %0d pair moved during stall", $time, idx);
            end
            stalled = o_coded_valid && !i_coded_ready;
            held    = o_coded.ab;
            if (o_coded_valid && i_coded_ready) begin
                if (got >= n_exp) begin
                    errors++;
                    $display("error at %0t: packet %0d extra pair %0d", $time, idx, got);
                end else if (o_coded.ab !== exp_q[got]) begin
                    errors++;
                    $display("error at %0t: packet %0d pair %0d got %b expected %b",
                             $time, idx, got, o_coded.ab, exp_q[got]);
                end
                got++;
            end
            if (o_tx_done) begin
                finished = 1'b1;
                if (got != n_exp) begin
                    errors++;
                    $display("error at %0t: packet %0d done after %0d of %0d pairs",
                             $time, idx, got, n_exp);
                end
            end else begin
                @(posedge clk);
                #1;
                i_tx_start    = 1'b0;
                i_coded_ready = ($urandom % 100) >= stall;
            end
        end
        if (!finished) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: packet %0d sent %0d of %0d pairs and never raised done",
                     idx, got, n_exp);
        end
    endtask

    initial begin
        int n_pkt;
        clk           = 1'b0;
        reset_int     = 1'b1;
        i_tx_start    = 1'b0;
        i_seed        = '0;
        i_coded_ready = 1'b1;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        void'($urandom(51272));
        for (int i = 0; i < STIM_SIZE; i++)
            stim[i] = '0;
        $readmemh("tb/tx_stim.txt", stim);
        repeat (4) @(posedge clk);
        #1;
        reset_int = 1'b0;

        // Quiet outputs with no start
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (o_coded_valid || o_tx_done || o_mem_addr != '0) begin
                errors++;
                $display("error at %0t: idle outputs valid=%b done=%b addr=%0d",
                         $time, o_coded_valid, o_tx_done, o_mem_addr);
            end
        end

        n_pkt = 0;
        while (n_pkt < STIM_SIZE / STIM_COLS && stim[n_pkt * STIM_COLS + 1] != 0
               && !timed_out) begin
            run_packet(n_pkt);
            n_pkt++;
        end
        if (n_pkt == 0) begin
            errors++;
            $display("no packets could be read from tb/tx_stim.txt");
        end

        // Done is a single pulse
        @(negedge clk);
        checks++;
        if (o_tx_done || o_coded_valid) begin
            errors++;
            $display("error at %0t: done or valid still high after the last packet", $time);
        end

        $display("packets=%0d checks=%0d errors=%0d", n_pkt, checks, errors);
        if (errors == 0 && !timed_out)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/dot11_tx_top.sv ====
/*
  Top of the 802.11a legacy transmit bit pipeline. Reads SIGNAL and PSDU
  from word memory and streams rate-1/2 coded bit pairs under ready.
*/
`timescale 1ns/1ps
`default_nettype none

module dot11_tx_top (
    input  wire                                   clk,
    input  wire                                   reset_int,
    input  logic                                  i_tx_start,
    input  logic [dot11_tx_pkg::SCRAM_W-1:0]      i_seed,
    output logic [dot11_tx_pkg::MEM_ADDR_W-1:0]   o_mem_addr,
    input  logic [dot11_tx_pkg::MEM_WORD_W-1:0]   i_mem_data,
    output dot11_tx_pkg::coded_pair_t             o_coded,
    output logic                                  o_coded_valid,
    input  logic                                  i_coded_ready,
    output logic                                  o_tx_done
);
    import dot11_tx_pkg::*;

    tx_beat_t              beat;
    logic                  scram_bit;
    logic                  crc_clear;
    logic                  crc_en;
    logic                  crc_bit;
    logic [FCS_BITS-1:0]   fcs;
    logic                  enc_bit;
    logic                  enc_en;
    logic                  enc_clear;

    tx_framer u_framer (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_tx_start  (i_tx_start),
        .o_mem_addr  (o_mem_addr),
        .i_mem_data  (i_mem_data),
        .o_beat      (beat),
        .i_scram_bit (scram_bit),
        .o_crc_clear (crc_clear),
        .o_crc_en    (crc_en),
        .o_crc_bit   (crc_bit),
        .i_fcs       (fcs),
        .o_enc_bit   (enc_bit),
        .o_enc_en    (enc_en),
        .o_enc_clear (enc_clear),
        .i_ready     (i_coded_ready),
        .o_tx_done   (o_tx_done)
    );

    // Idle beats carry neither seed load nor scramble, so ready alone is enough
    data_scrambler u_scrambler (
        .clk       (clk),
        .reset_int (reset_int),
        .i_beat    (beat),
        .i_accept  (i_coded_ready),
        .i_seed    (i_seed),
        .o_bit     (scram_bit)
    );

    fcs_crc32 u_fcs (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_crc_clear (crc_clear),
        .i_crc_en    (crc_en),
        .i_crc_bit   (crc_bit),
        .o_fcs       (fcs)
    );

    conv_encoder u_encoder (
        .clk       (clk),
        .reset_int (reset_int),
        .i_bit     (enc_bit),
        .i_en      (enc_en),
        .i_clear   (enc_clear),
        .i_ready   (i_coded_ready),
        .o_coded   (o_coded),
        .o_valid   (o_coded_valid)
    );

endmodule

`default_nettype wire

// ==== framer/tx_framer.sv ====
/*
  Field sequencer for one legacy PPDU: SIGNAL, SERVICE, payload, FCS, tail
  and pad. Addresses the word memory and feeds scrambler, CRC and encoder.
*/
`timescale 1ns/1ps
`default_nettype none

module tx_framer (
    input  wire                                   clk,
    input  wire                                   reset_int,
    input  logic                                  i_tx_start,
    output logic [dot11_tx_pkg::MEM_ADDR_W-1:0]   o_mem_addr,
    input  logic [dot11_tx_pkg::MEM_WORD_W-1:0]   i_mem_data,
    output dot11_tx_pkg::tx_beat_t                o_beat,
    input  logic                                  i_scram_bit,
    output logic                                  o_crc_clear,
    output logic                                  o_crc_en,
    output logic                                  o_crc_bit,
    input  logic [dot11_tx_pkg::FCS_BITS-1:0]     i_fcs,
    output logic                                  o_enc_bit,
    output logic                                  o_enc_en,
    output logic                                  o_enc_clear,
    input  logic                                  i_ready,
    output logic                                  o_tx_done
);
    import dot11_tx_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SIGNAL,
        ST_SERVICE,
        ST_PAYLOAD,
        ST_FCS,
        ST_TAIL,
        ST_PAD
    } fld_state_t;

    fld_state_t             state;
    logic [4:0]             fld_cnt;
    logic [PSDU_BIT_W-1:0]  psdu_cnt;
    logic [DBPS_W-1:0]      dbps_cnt;
    rate_info_t             rate_q;
    logic [PSDU_BIT_W-1:0]  payload_last;
    logic [MEM_ADDR_W-1:0]  last_addr;
    logic                   sym_end;
    logic                   sig_last;

    assign sym_end   = (dbps_cnt == rate_q.n_dbps - DBPS_W'(1));
    assign sig_last  = (fld_cnt == 5'(SIGNAL_BITS - 1));
    assign last_addr = MEM_ADDR_W'(PSDU_BASE_ADDR) + MEM_ADDR_W'(payload_last >> 6);

    //////////////////////////////////////////////////////////////////////
    // Rate and LENGTH capture from word 0
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == ST_SIGNAL && fld_cnt == 5'd0 && i_ready) begin
            rate_q       <= decode_rate(i_mem_data[3:0]);
            // Index of the last payload bit, LENGTH counts the 4 FCS bytes
            payload_last <= PSDU_BIT_W'({i_mem_data[16:5], 3'b000}) -
                            PSDU_BIT_W'(FCS_BITS + 1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Field sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            state      <= ST_IDLE;
            fld_cnt    <= '0;
            psdu_cnt   <= '0;
            dbps_cnt   <= '0;
            o_mem_addr <= '0;
            o_tx_done  <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (state == ST_IDLE) begin
                if (i_tx_start) begin
                    state      <= ST_SIGNAL;
                    fld_cnt    <= '0;
                    o_mem_addr <= '0;
                end
            end else if (i_ready) begin
                fld_cnt <= fld_cnt + 5'd1;
                // DATA bit position within the OFDM symbol
                if (state != ST_SIGNAL)
                    dbps_cnt <= sym_end ? '0 : dbps_cnt + DBPS_W'(1);

                case (state)
                    ST_SIGNAL: begin
                        if (sig_last) begin
                            state      <= ST_SERVICE;
                            fld_cnt    <= '0;
                            dbps_cnt   <= '0;
                            o_mem_addr <= MEM_ADDR_W'(PSDU_BASE_ADDR);
                        end
                    end
                    ST_SERVICE: begin
                        if (fld_cnt == 5'(SERVICE_BITS - 1)) begin
                            state    <= ST_PAYLOAD;
                            psdu_cnt <= '0;
                        end
                    end
                    ST_PAYLOAD: begin
                        psdu_cnt <= psdu_cnt + PSDU_BIT_W'(1);
                        // Next word only while payload bits remain
                        if (psdu_cnt[5:0] == 6'd63 && psdu_cnt != payload_last)
                            o_mem_addr <= o_mem_addr + MEM_ADDR_W'(1);
                        if (psdu_cnt == payload_last) begin
                            state   <= ST_FCS;
                            fld_cnt <= '0;
                        end
                    end
                    ST_FCS: begin
                        if (fld_cnt == 5'(FCS_BITS - 1)) begin
                            state   <= ST_TAIL;
                            fld_cnt <= '0;
                        end
                    end
                    ST_TAIL: begin
                        if (fld_cnt == 5'(TAIL_BITS - 1)) begin
                            if (sym_end) begin
                                state      <= ST_IDLE;
                                o_mem_addr <= '0;
                                o_tx_done  <= 1'b1;
                            end else begin
                                state <= ST_PAD;
                            end
                        end
                    end
                    ST_PAD: begin
                        if (sym_end) begin
                            state      <= ST_IDLE;
                            o_mem_addr <= '0;
                            o_tx_done  <= 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bit selection per field
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        o_beat = '0;
        case (state)
            ST_SIGNAL: begin
                o_beat.bit_raw   = i_mem_data[fld_cnt];
                o_beat.seed_load = sig_last;
            end
            ST_SERVICE: o_beat.scram_on = 1'b1;
            ST_PAYLOAD: begin
                o_beat.bit_raw  = i_mem_data[psdu_cnt[5:0]];
                o_beat.scram_on = 1'b1;
            end
            ST_FCS: begin
                o_beat.bit_raw  = i_fcs[fld_cnt];
                o_beat.scram_on = 1'b1;
            end
            ST_PAD: o_beat.scram_on = 1'b1;
            default: o_beat = '0;
        endcase
    end

    assign o_crc_clear = (state == ST_IDLE) && i_tx_start;
    assign o_crc_en    = (state == ST_PAYLOAD) && i_ready;
    assign o_crc_bit   = i_mem_data[psdu_cnt[5:0]];

    // Tail bits pass the scrambler untouched, so the encoder always takes its output
    assign o_enc_bit   = i_scram_bit;
    assign o_enc_en    = (state != ST_IDLE);
    assign o_enc_clear = o_crc_clear || (state == ST_SIGNAL && sig_last && i_ready);

    // Each field counter stays inside the field its state names
    a_state_legal: assert property (@(posedge clk) disable iff (reset_int)
        (state != ST_SIGNAL  || fld_cnt < 5'(SIGNAL_BITS)) &&
        (state != ST_SERVICE || fld_cnt < 5'(SERVICE_BITS)) &&
        (state != ST_TAIL    || fld_cnt < 5'(TAIL_BITS)) &&
        (state != ST_PAYLOAD || psdu_cnt <= payload_last));

    a_addr_bound: assert property (@(posedge clk) disable iff (reset_int)
        (state inside {ST_PAYLOAD, ST_FCS, ST_TAIL, ST_PAD}) |-> (o_mem_addr <= last_addr));

endmodule

`default_nettype wire

// ==== hdl/conv_encoder.sv ====
/*
  K=7 rate-1/2 convolutional encoder, generators 133 and 171 octal.
  The pair is combinational from the input bit and six history bits.
*/
`timescale 1ns/1ps
`default_nettype none

module conv_encoder (
    input  wire                         clk,
    input  wire                         reset_int,
    input  logic                        i_bit,
    input  logic                        i_en,
    input  logic                        i_clear,
    input  logic                        i_ready,
    output dot11_tx_pkg::coded_pair_t   o_coded,
    output logic                        o_valid
);

    // hist[0] is the most recent bit
    logic [5:0] hist;

    // A, taps at delays 0, 2, 3, 5, 6
    assign o_coded.ab[0] = i_bit ^ hist[1] ^ hist[2] ^ hist[4] ^ hist[5];
    // B, taps at delays 0, 1, 2, 3, 6
    assign o_coded.ab[1] = i_bit ^ hist[0] ^ hist[1] ^ hist[2] ^ hist[5];

    assign o_valid = i_en;

    always_ff @(posedge clk) begin
        if (reset_int || i_clear) begin
            hist <= '0;
        end else if (i_en && i_ready) begin
            hist <= {hist[4:0], i_bit};
        end
    end

    // A stalled pair must not move, whatever the framer and memory do
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_int)
        (o_valid && !i_ready) |=> $stable(o_coded));

endmodule

`default_nettype wire

// ==== hdl/fcs_crc32.sv ====
/*
  Bit-serial CRC-32 (IEEE 802.3, reflected) over the payload bits. The
  inverted register is the FCS, sent bit 0 first.
*/
`timescale 1ns/1ps
`default_nettype none

module fcs_crc32 (
    input  wire                                 clk,
    input  wire                                 reset_int,
    input  logic                                i_crc_clear,
    input  logic                                i_crc_en,
    input  logic                                i_crc_bit,
    output logic [dot11_tx_pkg::FCS_BITS-1:0]   o_fcs
);
    import dot11_tx_pkg::*;

    logic [FCS_BITS-1:0] crc;
    logic                fb;

    assign fb    = crc[0] ^ i_crc_bit;
    assign o_fcs = ~crc;

    always_ff @(posedge clk) begin
        if (reset_int || i_crc_clear) begin
            crc <= '1;
        end else if (i_crc_en) begin
            // Reflected form of 0x04C11DB7
            crc <= (crc >> 1) ^ (fb ? 32'hEDB8_8320 : '0);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/data_scrambler.sv ====
/*
  Seven-bit frame scrambler, x^7 + x^4 + 1. Seed loads on request, the
  state advances only on accepted scrambled beats.
*/
`timescale 1ns/1ps
`default_nettype none

module data_scrambler (
    input  wire                                clk,
    input  wire                                reset_int,
    input  dot11_tx_pkg::tx_beat_t             i_beat,
    input  logic                               i_accept,
    input  logic [dot11_tx_pkg::SCRAM_W-1:0]   i_seed,
    output logic                               o_bit
);
    import dot11_tx_pkg::*;

    logic [SCRAM_W-1:0] lfsr;
    logic               fb;

    assign fb    = lfsr[6] ^ lfsr[3];
    assign o_bit = i_beat.bit_raw ^ (i_beat.scram_on & fb);

    always_ff @(posedge clk) begin
        if (reset_int) begin
            lfsr <= '0;
        end else if (i_accept) begin
            if (i_beat.seed_load)
                lfsr <= i_seed;
            else if (i_beat.scram_on)
                lfsr <= {lfsr[5:0], fb};
        end
    end

endmodule

`default_nettype wire

// ==== common/dot11_tx_pkg.sv ====
/*
  Shared constants, field structs and the legacy rate table for the
  802.11a bit-level transmit front end. Imported by every RTL block.
*/
`default_nettype none

package dot11_tx_pkg;

    localparam int MEM_WORD_W     = 64;
    localparam int MEM_ADDR_W     = 10;
    localparam int SCRAM_W        = 7;
    localparam int SIGNAL_BITS    = 24;
    localparam int SERVICE_BITS   = 16;
    localparam int TAIL_BITS      = 6;
    localparam int FCS_BITS       = 32;
    localparam int DBPS_W         = 9;
    localparam int PSDU_BIT_W     = 16;
    localparam int PSDU_BASE_ADDR = 1;

    typedef logic [3:0] rate_code_t;

    typedef struct packed {
        rate_code_t        code;
        logic [DBPS_W-1:0] n_dbps;
    } rate_info_t;

    // One framer bit on its way to the scrambler
    typedef struct packed {
        logic bit_raw;
        logic scram_on;
        logic seed_load;
    } tx_beat_t;

    // ab[0] is output A (g0 = 133), ab[1] is output B (g1 = 171)
    typedef struct packed {
        logic [1:0] ab;
    } coded_pair_t;

    // RATE field to data bits per symbol, unknown codes fall back to 6 Mbps
    function automatic rate_info_t decode_rate(input rate_code_t code);
        rate_info_t info;
        info.code = code;
        case (code)
            4'b1011: info.n_dbps = 9'd24;
            4'b1111: info.n_dbps = 9'd36;
            4'b1010: info.n_dbps = 9'd48;
            4'b1110: info.n_dbps = 9'd72;
            4'b1001: info.n_dbps = 9'd96;
            4'b1101: info.n_dbps = 9'd144;
            4'b1000: info.n_dbps = 9'd192;
            4'b1100: info.n_dbps = 9'd216;
            default: begin
                info.code   = 4'b1011;
                info.n_dbps = 9'd24;
            end
        endcase
        return info;
    endfunction

endpackage

`default_nettype wire
